//--- hw/obj_pkg.sv
// sprite line-table engine shared definitions
// table sizes, the object record and the FSM state types

package obj_pkg;

    localparam int OBJ_COUNT   = 256;  // objects in one frame table
    localparam int FRAME_WORDS = 1024; // four words per object
    localparam int FRAME_AW    = 10;

    localparam int LINE_SLOTS  = 128;  // entries per video line
    localparam int SLOT_WORDS  = 4;    // only words 0..2 carry data

    // tile x must fall strictly between these
    localparam logic [15:0] X_MIN = 16'd48;
    localparam logic [15:0] X_MAX = 16'd448;

    // one sprite object as stored in the frame table
    // attr: [15:12] rows-1, [11:8] columns-1, [6] vflip, [5] hflip
    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] code;
        logic [15:0] attr;
    } obj_entry_t;

    typedef enum logic [2:0] {
        fs_idle,
        fs_read_words,
        fs_compare,
        fs_emit,
        fs_end_token
    } fetch_state_e;

    typedef enum logic [1:0] {
        ws_idle,
        ws_write_entry,
        ws_fill
    } writer_state_e;

endpackage

//--- hw/obj_stage_if.sv
// valid/ready link between sprite pipeline stages
// carries one object or one tile, plus the end-of-table marker

`timescale 1ns/1ps

interface obj_stage_if;

    logic                valid;
    logic                ready;
    obj_pkg::obj_entry_t obj;
    logic [3:0]          vsub;  // sub-line inside the tile
    logic [3:0]          row;   // tile row hit by the line
    logic                last;  // end token, obj is don't care

    modport src (
        output valid,
        output obj,
        output vsub,
        output row,
        output last,
        input  ready
    );

    modport dst (
        input  valid,
        input  obj,
        input  vsub,
        input  row,
        input  last,
        output ready
    );

endinterface

//--- hw/obj_frame_ram.sv
// frame table RAM
// host write port and a registered read port for the fetch stage

`timescale 1ns/1ps

module obj_frame_ram (
    input  logic                          clk,
    input  logic                          host_we,
    input  logic [obj_pkg::FRAME_AW-1:0]  host_addr,
    input  logic [15:0]                   host_wdata,
    input  logic [obj_pkg::FRAME_AW-1:0]  rd_addr,
    output logic [15:0]                   rd_data
);

    logic [15:0] mem [0:obj_pkg::FRAME_WORDS-1];

    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
    end

    // data shows up one clock after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hw/obj_fetch.sv
// fetch stage
// walks the frame table from the top object down, drops exact repeats
// and closes the table with an end token

`timescale 1ns/1ps

module obj_fetch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    output logic                          busy,
    output logic [obj_pkg::FRAME_AW-1:0]  rd_addr,
    input  logic [15:0]                   rd_data,
    obj_stage_if.src                      out
);

    obj_pkg::fetch_state_e state;

    logic [$clog2(obj_pkg::OBJ_COUNT)-1:0] obj_idx;
    logic [1:0]                            word_cnt;
    logic                                  first;     // never skip the first object
    logic [15:0]                           attr_q, code_q, y_q;
    obj_pkg::obj_entry_t                   cand, prev;
    logic                                  repeated;
    logic                                  at_bottom;

    assign rd_addr   = {obj_idx, word_cnt};
    assign at_bottom = (obj_idx == '0);

    // x word lands during the compare cycle
    always_comb begin
        cand.attr = attr_q;
        cand.code = code_q;
        cand.y    = y_q;
        cand.x    = rd_data;
        repeated  = (cand == prev);
    end

    assign out.vsub = '0;
    assign out.row  = '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= obj_pkg::fs_idle;
            busy      <= 1'b0;
            obj_idx   <= '0;
            word_cnt  <= '0;
            first     <= 1'b1;
            out.valid <= 1'b0;
            out.last  <= 1'b0;
        end else begin
            case (state)
                obj_pkg::fs_idle: begin
                    if (start) begin
                        busy     <= 1'b1;
                        obj_idx  <= '1;     // highest object first
                        word_cnt <= '0;
                        first    <= 1'b1;
                        state    <= obj_pkg::fs_read_words;
                    end
                end
                obj_pkg::fs_read_words: begin
                    word_cnt <= word_cnt + 2'd1;
                    if (word_cnt == 2'd3) begin
                        state <= obj_pkg::fs_compare;
                    end
                end
                obj_pkg::fs_compare: begin
                    first <= 1'b0;
                    if (repeated && !first) begin
                        // skip it, same as the one before
                        if (at_bottom) begin
                            out.valid <= 1'b1;
                            out.last  <= 1'b1;
                            state     <= obj_pkg::fs_end_token;
                        end else begin
                            obj_idx <= obj_idx - 1'b1;
                            state   <= obj_pkg::fs_read_words;
                        end
                    end else begin
                        out.valid <= 1'b1;
                        state     <= obj_pkg::fs_emit;
                    end
                end
                obj_pkg::fs_emit: begin
                    if (out.ready) begin
                        if (at_bottom) begin
                            out.last <= 1'b1;    // valid stays up for the token
                            state    <= obj_pkg::fs_end_token;
                        end else begin
                            out.valid <= 1'b0;
                            obj_idx   <= obj_idx - 1'b1;
                            state     <= obj_pkg::fs_read_words;
                        end
                    end
                end
                obj_pkg::fs_end_token: begin
                    if (out.ready) begin
                        out.valid <= 1'b0;
                        out.last  <= 1'b0;
                        busy      <= 1'b0;
                        state     <= obj_pkg::fs_idle;
                    end
                end
                default: state <= obj_pkg::fs_idle;
            endcase
        end
    end

    // object words and the compare history
    always_ff @(posedge clk) begin
        if (state == obj_pkg::fs_read_words) begin
            case (word_cnt)
                2'd1:    attr_q <= rd_data;
                2'd2:    code_q <= rd_data;
                2'd3:    y_q    <= rd_data;
                default: ;
            endcase
        end
        if (state == obj_pkg::fs_compare) begin
            prev    <= cand;
            out.obj <= cand;
        end
    end

endmodule

//--- hw/obj_zone_check.sv
// visibility stage
// keeps objects whose vertical span covers the current line and
// works out the tile row and sub-line for them

`timescale 1ns/1ps

module obj_zone_check (
    input  logic        clk,
    input  logic        rst,
    input  logic [8:0]  vrender,
    obj_stage_if.dst    in,
    obj_stage_if.src    out
);

    logic [8:0] diff;    // line offset into the object, mod 512
    logic [8:0] height;  // object height in lines
    logic       vis;
    logic       vflip;

    always_comb begin
        vflip  = in.obj.attr[6];
        diff   = vrender - in.obj.y[8:0];
        height = {1'b0, in.obj.attr[15:12], 4'd0} + 9'd16;
        vis    = (diff < height);
    end

    // single holding register, free when empty or draining
    assign in.ready = !out.valid || out.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (in.ready) begin
            // invisible objects are taken and dropped here
            out.valid <= in.valid && (in.last || vis);
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            out.obj  <= in.obj;
            out.last <= in.last;
            out.row  <= diff[7:4];
            out.vsub <= diff[3:0] ^ {4{vflip}};
        end
    end

endmodule

//--- hw/obj_tile_expand.sv
// tile expansion stage
// turns one visible object into one entry per horizontal tile, with
// code nibble offsets and flipped x order

`timescale 1ns/1ps

module obj_tile_expand (
    input  logic     clk,
    input  logic     rst,
    obj_stage_if.dst in,
    obj_stage_if.src out
);

    obj_pkg::obj_entry_t obj_q;
    obj_pkg::obj_entry_t tile;
    logic [3:0]          row_q, vsub_q;
    logic                last_q;
    logic                have_q;     // an object is being expanded
    logic [3:0]          n_q;        // current column
    logic [3:0]          mrow, npos;
    logic                final_tile;

    always_comb begin
        // vertical flip counts rows from the bottom
        mrow = obj_q.attr[6] ? obj_q.attr[15:12] - row_q : row_q;
        npos = obj_q.attr[5] ? obj_q.attr[11:8] - n_q : n_q;
        final_tile = last_q || (n_q == obj_q.attr[11:8]);

        tile      = obj_q;
        tile.code = {obj_q.code[15:8], obj_q.code[7:4] + mrow, obj_q.code[3:0] + n_q};
        tile.x    = obj_q.x + {8'd0, npos, 4'd0};   // 16 pixels per column
    end

    assign out.valid = have_q;
    assign out.obj   = tile;
    assign out.vsub  = vsub_q;
    assign out.row   = row_q;
    assign out.last  = last_q;

    // next object may load as the last tile leaves
    assign in.ready = !have_q || (out.ready && final_tile);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            have_q <= 1'b0;
            n_q    <= '0;
        end else if (in.valid && in.ready) begin
            have_q <= 1'b1;
            n_q    <= '0;
        end else if (have_q && out.ready) begin
            if (final_tile) begin
                have_q <= 1'b0;
            end else begin
                n_q <= n_q + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            obj_q  <= in.obj;
            row_q  <= in.row;
            vsub_q <= in.vsub;
            last_q <= in.last;
        end
    end

endmodule

//--- hw/obj_line_writer.sv
// line table writer
// fills one half of the double-buffered line table per build while
// the renderer reads the other half

`timescale 1ns/1ps

module obj_line_writer (
    input  logic        clk,
    input  logic        rst,
    input  logic [8:0]  vrender,
    obj_stage_if.dst    in,
    output logic        done,
    input  logic [8:0]  line_addr,
    output logic [15:0] line_data
);

    logic [15:0] line_mem [0:2*obj_pkg::LINE_SLOTS*obj_pkg::SLOT_WORDS-1];

    obj_pkg::writer_state_e state;

    logic [$clog2(obj_pkg::LINE_SLOTS):0] count;   // 0..128
    logic                                 full;
    logic [1:0]                           word;
    logic [15:0]                          code_q, x_q;
    logic                                 in_window;
    logic                                 we;
    logic [1:0]                           wword;
    logic [15:0]                          wdata;

    assign full      = count[$clog2(obj_pkg::LINE_SLOTS)];
    assign in_window = (x_q > obj_pkg::X_MIN) && (x_q < obj_pkg::X_MAX);
    assign in.ready  = (state == obj_pkg::ws_idle);

    // write port mux, word 0 goes in on the accept cycle
    always_comb begin
        we    = 1'b0;
        wword = word;
        wdata = '1;
        case (state)
            obj_pkg::ws_idle: begin
                we    = in.valid && !in.last && !full;
                wword = 2'd0;
                wdata = {4'd0, in.vsub, in.obj.attr[7:0]};
            end
            obj_pkg::ws_write_entry: begin
                we    = 1'b1;
                wdata = (word == 2'd1) ? code_q : x_q;
            end
            obj_pkg::ws_fill: we = 1'b1;   // all ones
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (we) begin
            line_mem[{vrender[0], count[6:0], wword}] <= wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= obj_pkg::ws_idle;
            count <= '0;
            word  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                obj_pkg::ws_idle: begin
                    if (in.valid) begin
                        word <= (in.last) ? 2'd0 : 2'd1;
                        if (in.last && full) begin
                            done  <= 1'b1;   // nothing left to fill
                            count <= '0;
                        end else if (in.last) begin
                            state <= obj_pkg::ws_fill;
                        end else if (!full) begin
                            state <= obj_pkg::ws_write_entry;
                        end
                        // tiles past a full line are dropped
                    end
                end
                obj_pkg::ws_write_entry: begin
                    word <= word + 2'd1;
                    if (word == 2'd2) begin
                        if (in_window) count <= count + 1'b1;   // else slot is reused
                        state <= obj_pkg::ws_idle;
                    end
                end
                obj_pkg::ws_fill: begin
                    word <= word + 2'd1;
                    if (word == 2'd2) begin
                        word <= 2'd0;
                        if (count == obj_pkg::LINE_SLOTS - 1) begin
                            done  <= 1'b1;
                            count <= '0;
                            state <= obj_pkg::ws_idle;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                default: state <= obj_pkg::ws_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == obj_pkg::ws_idle && in.valid && !in.last) begin
            code_q <= in.obj.code;
            x_q    <= in.obj.x;
        end
    end

    // renderer side reads the half not being built
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_data <= '0;
        end else begin
            line_data <= line_mem[{~vrender[0], line_addr}];
        end
    end

endmodule

//--- hw/obj_line_engine.sv
// sprite line-table engine top level
// frame RAM, fetch, visibility, expansion and line writer in a chain

`timescale 1ns/1ps

module obj_line_engine (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          host_we,
    input  logic [obj_pkg::FRAME_AW-1:0]  host_addr,
    input  logic [15:0]                   host_wdata,
    input  logic [8:0]                    vrender,
    input  logic                          start,
    output logic                          busy,
    output logic                          done,
    input  logic [8:0]                    line_addr,
    output logic [15:0]                   line_data
);

    logic [obj_pkg::FRAME_AW-1:0] rd_addr;
    logic [15:0]                  rd_data;
    logic                         fetch_busy;
    logic                         tail_busy;    // end token still in the pipe

    obj_stage_if f2z ();
    obj_stage_if z2e ();
    obj_stage_if e2w ();

    // fetch covers start to end token, tail_busy covers the rest up to done
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail_busy <= 1'b0;
        end else if (done) begin
            tail_busy <= 1'b0;
        end else if (f2z.valid && f2z.ready && f2z.last) begin
            tail_busy <= 1'b1;
        end
    end

    assign busy = fetch_busy | tail_busy;

    obj_frame_ram u_ram (
        .clk        (clk),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    obj_fetch u_fetch (
        .clk     (clk),
        .rst     (rst),
        .start   (start & ~busy),
        .busy    (fetch_busy),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .out     (f2z.src)
    );

    obj_zone_check u_zone (
        .clk     (clk),
        .rst     (rst),
        .vrender (vrender),
        .in      (f2z.dst),
        .out     (z2e.src)
    );

    obj_tile_expand u_expand (
        .clk (clk),
        .rst (rst),
        .in  (z2e.dst),
        .out (e2w.src)
    );

    obj_line_writer u_writer (
        .clk       (clk),
        .rst       (rst),
        .vrender   (vrender),
        .in        (e2w.dst),
        .done      (done),
        .line_addr (line_addr),
        .line_data (line_data)
    );

endmodule

//--- tb/tb_clock.sv
// testbench clock source
// free-running 100 ns clock

`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #50 clk = ~clk;   // half of the 100 ns period

endmodule

//--- tb/obj_line_assert.sv
// protocol checks on the sprite line-table engine ports
// done width, quiet outputs in reset, no start while busy

`timescale 1ns/1ps

module obj_line_assert (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic done
);

    int fail_count = 0;

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    // async reset has cleared the outputs by the next edge
    reset_quiet: assert property (@(posedge clk) rst |=> (!busy && !done))
        else begin
            $error("busy or done high while in reset");
            fail_count++;
        end

    start_idle: assert property (@(posedge clk) disable iff (rst) busy |-> !start)
        else begin
            $error("start raised while a build was still busy");
            fail_count++;
        end

endmodule

bind obj_line_engine obj_line_assert u_assert (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .busy  (busy),
    .done  (done)
);

//--- tb/obj_line_tb.sv
// testbench for the sprite line-table engine
// random frame tables, a line model, and a full readback of each build

`timescale 1ns/1ps

module obj_line_tb;

    localparam int BUILDS       = 12;
    localparam int WATCH_CYCLES = BUILDS * (obj_pkg::OBJ_COUNT * 200 + obj_pkg::LINE_SLOTS * 4);
    localparam int READ_WORDS   = obj_pkg::LINE_SLOTS * 3;

    logic        clk;
    logic        rst;
    logic        host_we;
    logic [9:0]  host_addr;
    logic [15:0] host_wdata;
    logic [8:0]  vrender;
    logic        start;
    logic        busy;
    logic        done;
    logic [8:0]  line_addr;
    logic [15:0] line_data;

    obj_pkg::obj_entry_t tbl [0:obj_pkg::OBJ_COUNT-1];   // host copy of the frame table
    logic [15:0]         exp_line [0:READ_WORDS-1];
    logic [15:0]         exp_prev [0:READ_WORDS-1];       // previous build for test 5

    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    tb_clock u_clock (.clk(clk));

    obj_line_engine DUT (
        .clk        (clk),
        .rst        (rst),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .vrender    (vrender),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .line_addr  (line_addr),
        .line_data  (line_data)
    );

    task automatic check_value(input logic [15:0] got, input logic [15:0] want,
                               input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    // near_pct of the objects are placed so they cover the given line
    task automatic make_random_table(input int max_m, input int max_n, input logic [8:0] line,
                                     input int near_pct, input int dup_pct,
                                     input int x_lo, input int x_span);
        int         tm;
        int         tn;
        logic [8:0] yl;
        for (int k = 0; k < obj_pkg::OBJ_COUNT; k++) begin
            tm = $urandom % (max_m + 1);
            tn = $urandom % (max_n + 1);
            tbl[k].attr = {tm[3:0], tn[3:0], 8'($urandom)};
            tbl[k].code = 16'($urandom);
            tbl[k].x    = 16'(x_lo + $urandom % x_span);
            if ($urandom % 100 < near_pct) begin
                yl        = line - 9'($urandom % (16 * (tm + 1)));
                tbl[k].y  = {7'd0, yl};
            end else begin
                tbl[k].y  = 16'($urandom);
            end
        end
        for (int k = obj_pkg::OBJ_COUNT - 2; k >= 0; k--) begin
            if ($urandom % 100 < dup_pct) tbl[k] = tbl[k+1];   // copy of the object above
        end
    endtask

    task automatic load_frame_ram();
        for (int k = 0; k < obj_pkg::OBJ_COUNT; k++) begin
            for (int w = 0; w < 4; w++) begin
                host_we   = 1'b1;
                host_addr = 10'(4 * k + w);
                case (w)
                    0:       host_wdata = tbl[k].attr;
                    1:       host_wdata = tbl[k].code;
                    2:       host_wdata = tbl[k].y;
                    default: host_wdata = tbl[k].x;
                endcase
                @(negedge clk);
            end
        end
        host_we = 1'b0;
    endtask

    // expected line table, straight from the object and tile rules
    task automatic build_line_model(input logic [8:0] line);
        int                  count;
        obj_pkg::obj_entry_t o;
        logic [8:0]          diff;
        logic [8:0]          height;
        logic [3:0]          tm;
        logic [3:0]          tn;
        logic [3:0]          row;
        logic [3:0]          vsub;
        logic [3:0]          mrow;
        logic [3:0]          npos;
        logic [3:0]          n4;
        logic [15:0]         code;
        logic [15:0]         x;
        count = 0;
        for (int i = 0; i < READ_WORDS; i++) exp_line[i] = 16'hffff;
        for (int k = obj_pkg::OBJ_COUNT - 1; k >= 0; k--) begin
            if (k != obj_pkg::OBJ_COUNT - 1 && tbl[k] == tbl[k+1]) continue;
            o      = tbl[k];
            tm     = o.attr[15:12];
            tn     = o.attr[11:8];
            diff   = line - o.y[8:0];
            height = 9'(16 * (tm + 1));
            if (diff >= height) continue;
            row  = diff[7:4];
            vsub = o.attr[6] ? ~diff[3:0] : diff[3:0];
            mrow = o.attr[6] ? tm - row : row;
            for (int n = 0; n <= tn; n++) begin
                n4   = 4'(n);
                npos = o.attr[5] ? tn - n4 : n4;   // hflip walks columns backwards
                code = {o.code[15:8], 4'(o.code[7:4] + mrow), 4'(o.code[3:0] + n4)};
                x    = o.x + 16'(npos) * 16'd16;
                if (x > obj_pkg::X_MIN && x < obj_pkg::X_MAX && count < obj_pkg::LINE_SLOTS) begin
                    exp_line[3 * count]     = {4'd0, vsub, o.attr[7:0]};
                    exp_line[3 * count + 1] = code;
                    exp_line[3 * count + 2] = x;
                    count++;
                end
            end
        end
    endtask

    task automatic run_build(input logic [8:0] line);
        while (busy) @(negedge clk);
        vrender = line;
        start   = 1'b1;
        @(negedge clk);
        start   = 1'b0;
        while (!done) begin
            check_value({15'd0, busy}, 16'd1, "busy during build");
            @(negedge clk);
        end
    endtask

    task automatic read_line_table(input bit use_prev, input string tag);
        logic [15:0] want;
        int          slot;
        int          word;
        for (int i = 0; i < READ_WORDS; i++) begin
            slot      = i / 3;
            word      = i % 3;
            line_addr = {slot[6:0], word[1:0]};
            @(negedge clk);   // one cycle read latency
            want = use_prev ? exp_prev[i] : exp_line[i];
            check_value(line_data, want, $sformatf("%s slot %0d word %0d", tag, slot, word));
        end
    endtask

    task automatic build_and_check(input logic [8:0] line, input string tag);
        build_line_model(line);
        run_build(line);
        vrender = line + 9'd1;   // renderer now sees this build's half
        read_line_table(1'b0, tag);
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", num, name, errors - errs_before);
        end
    endtask

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, a build never finished", WATCH_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int         mark;
        int         pick;
        int         afails;
        logic [8:0] line;
        rst          = 1'b1;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        vrender      = '0;
        start        = 1'b0;
        line_addr    = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h645a0b7f));
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        mark = errors;
        repeat (3) begin
            line = 9'($urandom);
            make_random_table(0, 0, line, 10, 0, 0, 512);
            load_frame_ram();
            build_and_check(line, "single row");
        end
        report_test(1, "single-row objects", mark);

        mark = errors;
        make_random_table(3, 3, 9'd0, 0, 0, 0, 512);
        load_frame_ram();
        repeat (4) begin
            pick = $urandom % obj_pkg::OBJ_COUNT;   // a line inside this object
            line = tbl[pick].y[8:0] + 9'($urandom % (16 * (tbl[pick].attr[15:12] + 1)));
            build_and_check(line, "multi tile");
        end
        report_test(2, "multi-tile expansion", mark);

        mark = errors;
        repeat (2) begin
            line = 9'($urandom);
            make_random_table(0, 1, line, 15, 30, 0, 512);
            for (int b = 0; b < 4; b++) begin
                case (b)
                    0:       tbl[20 + b].x = 16'd48;
                    1:       tbl[20 + b].x = 16'd49;
                    2:       tbl[20 + b].x = 16'd447;
                    default: tbl[20 + b].x = 16'd448;
                endcase
                tbl[20 + b].y         = {7'd0, line};
                tbl[20 + b].attr[15:8] = 8'h00;
            end
            load_frame_ram();
            build_and_check(line, "repeat window");
        end
        report_test(3, "repeat suppression and x window", mark);

        mark = errors;
        line = 9'($urandom);
        make_random_table(0, 3, line, 100, 0, 64, 320);   // far more than 128 tiles
        load_frame_ram();
        build_and_check(line, "overflow");
        report_test(4, "overflow", mark);

        mark = errors;
        line = 9'($urandom);
        make_random_table(1, 2, line, 30, 10, 0, 512);
        load_frame_ram();
        build_and_check(line, "buffer a");
        exp_prev = exp_line;
        make_random_table(1, 2, line + 9'd1, 30, 10, 0, 512);
        load_frame_ram();
        build_line_model(line + 9'd1);
        fork
            run_build(line + 9'd1);
            read_line_table(1'b1, "buffer a during b");
        join
        vrender = line + 9'd2;
        read_line_table(1'b0, "buffer b");
        report_test(5, "double buffering", mark);

        afails = DUT.u_assert.fail_count;
        $display("%0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion failures",
                 tests_run, tests_failed, checks, errors, afails);
        if (errors == 0 && tests_failed == 0 && afails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
hw/obj_pkg.sv
hw/obj_stage_if.sv
hw/obj_frame_ram.sv
hw/obj_fetch.sv
hw/obj_zone_check.sv
hw/obj_tile_expand.sv
hw/obj_line_writer.sv
hw/obj_line_engine.sv
tb/tb_clock.sv
tb/obj_line_assert.sv
tb/obj_line_tb.sv

//--- build.sh
#!/bin/sh
# compile and run the sprite line-table engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module obj_line_tb -o obj_line_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/obj_line_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation clean"
exit 0
